// File: design/gx_video_pkg.sv
package gx_video_pkg;

    // CPU data bytes and mode register values
    typedef logic [7:0] byte_t;

    // CRTC memory address
    typedef logic [13:0] ma_t;

    // CRTC raster address
    typedef logic [4:0] ra_t;

    // ASIC RAM address
    typedef logic [13:0] asic_addr_t;

    // Motherboard colour channel
    typedef logic [1:0] chan2_t;

    // Plus colour channel
    typedef logic [3:0] chan4_t;

    // Sprite number
    typedef logic [3:0] sprite_id_t;

    // High byte of the gate array I/O port
    localparam byte_t ga_port_hi = 8'hBC;

    // Register select codes, taken from data bits 4:0
    localparam logic [4:0] reg_config = 5'h00;
    localparam logic [4:0] reg_asic   = 5'h02;

    // ASIC mode codes that hand the video path to the Plus hardware
    localparam byte_t asic_mode_palette = 8'h02;
    localparam byte_t asic_mode_sprite  = 8'h62;
    localparam byte_t asic_mode_blend   = 8'h82;

endpackage

// File: design/mode_regs.sv
`timescale 1ns/1ps

module mode_regs (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                plus_mode,
    input  logic [15:0]         cpu_addr,
    input  gx_video_pkg::byte_t cpu_data,
    input  logic                cpu_wr,
    output gx_video_pkg::byte_t config_mode,
    output gx_video_pkg::byte_t asic_mode,
    output logic                asic_active,
    output logic                asic_ram_wr,
    output gx_video_pkg::byte_t asic_ram_din
);

    logic port_hit;
    logic reg_write;
    logic plus_code;
    logic asic_en;

    // Any CPU write aimed at the gate array port
    assign port_hit  = cpu_wr && (cpu_addr[15:8] == gx_video_pkg::ga_port_hi);

    // Register writes only use the even address
    assign reg_write = port_hit && !cpu_addr[0];

    // Only three mode codes hand over to the Plus path
    assign plus_code = (cpu_data == gx_video_pkg::asic_mode_palette) ||
                       (cpu_data == gx_video_pkg::asic_mode_sprite)  ||
                       (cpu_data == gx_video_pkg::asic_mode_blend);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            config_mode <= '0;
            asic_mode   <= '0;
            asic_en     <= 1'b0;
        end else if (reg_write) begin
            case (cpu_data[4:0])
                gx_video_pkg::reg_config: begin
                    config_mode <= cpu_data;
                end
                gx_video_pkg::reg_asic: begin
                    asic_mode <= cpu_data;
                    // plus_mode sampled at the write itself
                    asic_en   <= plus_code && plus_mode;
                end
                default: begin
                    // Other selects are ignored
                end
            endcase
        end
    end

    // Dropping plus_mode later switches the ASIC off again
    assign asic_active = asic_en && plus_mode;

    // CPU data goes straight through to ASIC RAM
    assign asic_ram_wr  = asic_en && port_hit;
    assign asic_ram_din = cpu_data;

    // Active ASIC always runs on one of the known Plus modes
    a_active_mode : assert property (
        @(posedge clk_sys) disable iff (reset)
        asic_active |-> (asic_mode == gx_video_pkg::asic_mode_palette ||
                         asic_mode == gx_video_pkg::asic_mode_sprite  ||
                         asic_mode == gx_video_pkg::asic_mode_blend)
    );

endmodule

// File: design/palette_fetch.sv
`timescale 1ns/1ps

module palette_fetch (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     cclk_en,
    input  logic                     crtc_de,
    input  gx_video_pkg::ma_t        crtc_ma,
    input  gx_video_pkg::ra_t        crtc_ra,
    input  logic                     asic_active,
    input  gx_video_pkg::byte_t      asic_ram_q,
    input  gx_video_pkg::chan2_t     r_in,
    input  gx_video_pkg::chan2_t     g_in,
    input  gx_video_pkg::chan2_t     b_in,
    output gx_video_pkg::asic_addr_t asic_ram_addr,
    output logic                     asic_ram_rd,
    output gx_video_pkg::chan4_t     palette_r,
    output gx_video_pkg::chan4_t     palette_g,
    output gx_video_pkg::chan4_t     palette_b
);

    logic [4:0]           palette_ptr;
    gx_video_pkg::chan2_t src_r;
    gx_video_pkg::chan2_t src_g;
    gx_video_pkg::chan2_t src_b;

    // Pointer picks one of 32 palette entries
    assign palette_ptr = {crtc_ra[2:0], crtc_ma[1:0]};

    // Without the ASIC the RAM just sees the CRTC address
    assign asic_ram_addr = asic_active ? {9'b0, palette_ptr} : crtc_ma;

    // One read per visible pixel strobe
    assign asic_ram_rd = cclk_en && crtc_de && asic_active;

    // Returned byte packs RGB as 2 bits each, blue on top
    always_comb begin
        if (asic_active) begin
            src_r = asic_ram_q[1:0];
            src_g = asic_ram_q[3:2];
            src_b = asic_ram_q[5:4];
        end else begin
            src_r = r_in;
            src_g = g_in;
            src_b = b_in;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            palette_r <= '0;
            palette_g <= '0;
            palette_b <= '0;
        end else if (cclk_en && crtc_de) begin
            palette_r <= {2'b00, src_r};
            palette_g <= {2'b00, src_g};
            palette_b <= {2'b00, src_b};
        end
    end

    // A read lands in the latch on the next clock
    a_read_latch : assert property (
        @(posedge clk_sys) disable iff (reset)
        asic_ram_rd |-> crtc_de ##1 (palette_r == {2'b00, $past(asic_ram_q[1:0])})
    );

endmodule

// File: design/sprite_detect.sv
`timescale 1ns/1ps

module sprite_detect #(
    parameter logic [3:0] sprite_zone = 4'hF
) (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     cclk_en,
    input  logic                     crtc_de,
    input  gx_video_pkg::ma_t        crtc_ma,
    output logic                     sprite_hit,
    output logic                     sprite_active_out,
    output gx_video_pkg::sprite_id_t sprite_id_out
);

    gx_video_pkg::sprite_id_t sprite_id_s1;

    // Stage 1 looks at the top address bits, stage 2 trails by a pixel
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sprite_hit        <= 1'b0;
            sprite_id_s1      <= '0;
            sprite_active_out <= 1'b0;
            sprite_id_out     <= '0;
        end else if (cclk_en) begin
            if (crtc_de) begin
                sprite_hit        <= (crtc_ma[13:10] == sprite_zone);
                sprite_id_s1      <= crtc_ma[9:6];
                sprite_active_out <= sprite_hit;
                sprite_id_out     <= sprite_id_s1;
            end else begin
                // Blanking flushes both stages
                sprite_hit        <= 1'b0;
                sprite_id_s1      <= '0;
                sprite_active_out <= 1'b0;
                sprite_id_out     <= '0;
            end
        end
    end

    // Blank strobe leaves no hit for the mixer
    a_blank_clear : assert property (
        @(posedge clk_sys) disable iff (reset)
        (cclk_en && !crtc_de) |=> !sprite_hit
    );

endmodule

// File: design/color_mixer.sv
`timescale 1ns/1ps

module color_mixer (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 cclk_en,
    input  logic                 crtc_de,
    input  gx_video_pkg::byte_t  config_mode,
    input  gx_video_pkg::byte_t  asic_mode,
    input  logic                 asic_active,
    input  logic                 sprite_hit,
    input  gx_video_pkg::chan4_t palette_r,
    input  gx_video_pkg::chan4_t palette_g,
    input  gx_video_pkg::chan4_t palette_b,
    input  gx_video_pkg::chan2_t r_in,
    input  gx_video_pkg::chan2_t g_in,
    input  gx_video_pkg::chan2_t b_in,
    output gx_video_pkg::chan4_t r_out,
    output gx_video_pkg::chan4_t g_out,
    output gx_video_pkg::chan4_t b_out
);

    // Per-pixel colour source
    localparam logic [1:0] sel_black   = 2'd0;
    localparam logic [1:0] sel_input   = 2'd1;
    localparam logic [1:0] sel_palette = 2'd2;
    localparam logic [1:0] sel_blend   = 2'd3;

    logic [1:0] sel;

    // One channel of the mix, same for R, G and B
    function automatic gx_video_pkg::chan4_t mix_chan(
        input logic [1:0]           mode_sel,
        input gx_video_pkg::chan4_t pal,
        input gx_video_pkg::chan2_t mb
    );
        gx_video_pkg::chan4_t mb_wide;
        gx_video_pkg::chan4_t sum;
        mb_wide = {2'b00, mb};
        // Sum wraps at 4 bits before halving
        sum     = pal + mb_wide;
        case (mode_sel)
            sel_input:   mix_chan = mb_wide;
            sel_palette: mix_chan = pal;
            sel_blend:   mix_chan = {1'b0, sum[3:1]};
            default:     mix_chan = '0;
        endcase
    endfunction

    always_comb begin
        if (!crtc_de) begin
            sel = sel_black;
        end else if (config_mode == 8'h00 || !asic_active) begin
            // Plain CPC colour path
            sel = sel_input;
        end else begin
            case (asic_mode)
                gx_video_pkg::asic_mode_sprite: sel = sprite_hit ? sel_palette : sel_input;
                gx_video_pkg::asic_mode_blend:  sel = sel_blend;
                default:                        sel = sel_palette;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            r_out <= '0;
            g_out <= '0;
            b_out <= '0;
        end else if (cclk_en) begin
            r_out <= mix_chan(sel, palette_r, r_in);
            g_out <= mix_chan(sel, palette_g, g_in);
            b_out <= mix_chan(sel, palette_b, b_in);
        end
    end

endmodule

// File: design/gx_video_top.sv
`timescale 1ns/1ps

module gx_video_top #(
    parameter logic [3:0] sprite_zone = 4'hF
) (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     plus_mode,

    // CRTC side
    input  logic                     cclk_en,
    input  gx_video_pkg::ma_t        crtc_ma,
    input  gx_video_pkg::ra_t        crtc_ra,
    input  logic                     crtc_de,

    // CPU side
    input  logic [15:0]              cpu_addr,
    input  gx_video_pkg::byte_t      cpu_data,
    input  logic                     cpu_wr,

    // Motherboard colour
    input  gx_video_pkg::chan2_t     r_in,
    input  gx_video_pkg::chan2_t     g_in,
    input  gx_video_pkg::chan2_t     b_in,

    // Mixed colour out
    output gx_video_pkg::chan4_t     r_out,
    output gx_video_pkg::chan4_t     g_out,
    output gx_video_pkg::chan4_t     b_out,

    // Sprite status
    output logic                     sprite_active_out,
    output gx_video_pkg::sprite_id_t sprite_id_out,

    // ASIC RAM port
    output gx_video_pkg::asic_addr_t asic_ram_addr,
    output logic                     asic_ram_rd,
    input  gx_video_pkg::byte_t      asic_ram_q,
    output logic                     asic_ram_wr,
    output gx_video_pkg::byte_t      asic_ram_din
);

    gx_video_pkg::byte_t  config_mode;
    gx_video_pkg::byte_t  asic_mode;
    logic                 asic_active;
    logic                 sprite_hit;
    gx_video_pkg::chan4_t palette_r;
    gx_video_pkg::chan4_t palette_g;
    gx_video_pkg::chan4_t palette_b;

    mode_regs mode_regs_i (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .plus_mode    (plus_mode),
        .cpu_addr     (cpu_addr),
        .cpu_data     (cpu_data),
        .cpu_wr       (cpu_wr),
        .config_mode  (config_mode),
        .asic_mode    (asic_mode),
        .asic_active  (asic_active),
        .asic_ram_wr  (asic_ram_wr),
        .asic_ram_din (asic_ram_din)
    );

    palette_fetch palette_fetch_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .cclk_en       (cclk_en),
        .crtc_de       (crtc_de),
        .crtc_ma       (crtc_ma),
        .crtc_ra       (crtc_ra),
        .asic_active   (asic_active),
        .asic_ram_q    (asic_ram_q),
        .r_in          (r_in),
        .g_in          (g_in),
        .b_in          (b_in),
        .asic_ram_addr (asic_ram_addr),
        .asic_ram_rd   (asic_ram_rd),
        .palette_r     (palette_r),
        .palette_g     (palette_g),
        .palette_b     (palette_b)
    );

    sprite_detect #(
        .sprite_zone (sprite_zone)
    ) sprite_detect_i (
        .clk_sys           (clk_sys),
        .reset             (reset),
        .cclk_en           (cclk_en),
        .crtc_de           (crtc_de),
        .crtc_ma           (crtc_ma),
        .sprite_hit        (sprite_hit),
        .sprite_active_out (sprite_active_out),
        .sprite_id_out     (sprite_id_out)
    );

    color_mixer color_mixer_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .cclk_en     (cclk_en),
        .crtc_de     (crtc_de),
        .config_mode (config_mode),
        .asic_mode   (asic_mode),
        .asic_active (asic_active),
        .sprite_hit  (sprite_hit),
        .palette_r   (palette_r),
        .palette_g   (palette_g),
        .palette_b   (palette_b),
        .r_in        (r_in),
        .g_in        (g_in),
        .b_in        (b_in),
        .r_out       (r_out),
        .g_out       (g_out),
        .b_out       (b_out)
    );

endmodule

// File: verification/video_tb_vectors.svh
// Columns: cfg, asic, plus at write, plus, ma, ra, de, r, g, b, q, random,
// then expected r, g, b, sprite flag, sprite id, RAM address, RAM read strobe
task automatic load_vectors();
    // Motherboard path, visible then blanked
    vectors.push_back(vector_t'{8'h00, 8'h22, 1'b0, 1'b0, 14'h0123, 5'h00, 1'b1,
        2'd1, 2'd2, 2'd3, 8'h00, 1'b0, 4'h1, 4'h2, 4'h3, 1'b0, 4'h4, 14'h0123, 1'b0});
    vectors.push_back(vector_t'{8'h00, 8'h22, 1'b0, 1'b0, 14'h0123, 5'h00, 1'b0,
        2'd1, 2'd2, 2'd3, 8'h00, 1'b0, 4'h0, 4'h0, 4'h0, 1'b0, 4'h0, 14'h0123, 1'b0});
    // Palette mode
    vectors.push_back(vector_t'{8'h80, 8'h02, 1'b1, 1'b1, 14'h0005, 5'h03, 1'b1,
        2'd3, 2'd3, 2'd3, 8'h39, 1'b0, 4'h1, 4'h2, 4'h3, 1'b0, 4'h0, 14'h000D, 1'b1});
    vectors.push_back(vector_t'{8'h80, 8'h02, 1'b1, 1'b1, 14'h0002, 5'h1F, 1'b1,
        2'd0, 2'd0, 2'd0, 8'h00, 1'b1, 4'h0, 4'h0, 4'h0, 1'b0, 4'h0, 14'h001E, 1'b1});
    // Blend mode
    vectors.push_back(vector_t'{8'h80, 8'h82, 1'b1, 1'b1, 14'h0003, 5'h01, 1'b1,
        2'd1, 2'd2, 2'd3, 8'h3F, 1'b0, 4'h2, 4'h2, 4'h3, 1'b0, 4'h0, 14'h0007, 1'b1});
    vectors.push_back(vector_t'{8'h80, 8'h82, 1'b1, 1'b1, 14'h0010, 5'h02, 1'b1,
        2'd0, 2'd0, 2'd0, 8'h00, 1'b1, 4'h0, 4'h0, 4'h0, 1'b0, 4'h0, 14'h0008, 1'b1});
    vectors.push_back(vector_t'{8'h80, 8'h82, 1'b1, 1'b1, 14'h0010, 5'h02, 1'b0,
        2'd1, 2'd1, 2'd1, 8'h15, 1'b0, 4'h0, 4'h0, 4'h0, 1'b0, 4'h0, 14'h0008, 1'b0});
    // Sprite priority, zone F hit, zone E miss, then blanking
    vectors.push_back(vector_t'{8'h80, 8'h62, 1'b1, 1'b1, 14'h3D41, 5'h04, 1'b1,
        2'd0, 2'd0, 2'd0, 8'h2A, 1'b0, 4'h2, 4'h2, 4'h2, 1'b1, 4'h5, 14'h0011, 1'b1});
    vectors.push_back(vector_t'{8'h80, 8'h62, 1'b1, 1'b1, 14'h3941, 5'h04, 1'b1,
        2'd1, 2'd2, 2'd3, 8'h2A, 1'b0, 4'h1, 4'h2, 4'h3, 1'b0, 4'h5, 14'h0011, 1'b1});
    vectors.push_back(vector_t'{8'h80, 8'h62, 1'b1, 1'b1, 14'h3FC2, 5'h00, 1'b1,
        2'd0, 2'd0, 2'd0, 8'h00, 1'b1, 4'h0, 4'h0, 4'h0, 1'b1, 4'hF, 14'h0002, 1'b1});
    vectors.push_back(vector_t'{8'h80, 8'h62, 1'b1, 1'b1, 14'h3FC2, 5'h00, 1'b0,
        2'd1, 2'd1, 2'd1, 8'h00, 1'b0, 4'h0, 4'h0, 4'h0, 1'b0, 4'h0, 14'h0002, 1'b0});
    // plus_mode low at the write, then dropped after an enabling write
    vectors.push_back(vector_t'{8'h80, 8'h02, 1'b0, 1'b0, 14'h1234, 5'h03, 1'b1,
        2'd2, 2'd1, 2'd0, 8'h3F, 1'b0, 4'h2, 4'h1, 4'h0, 1'b0, 4'h8, 14'h1234, 1'b0});
    vectors.push_back(vector_t'{8'h80, 8'h02, 1'b1, 1'b0, 14'h1234, 5'h03, 1'b1,
        2'd2, 2'd1, 2'd0, 8'h3F, 1'b0, 4'h2, 4'h1, 4'h0, 1'b0, 4'h8, 14'h1234, 1'b0});
    // config_mode zero keeps the inputs even with the ASIC on
    vectors.push_back(vector_t'{8'h00, 8'h02, 1'b1, 1'b1, 14'h0001, 5'h02, 1'b1,
        2'd3, 2'd0, 2'd1, 8'h15, 1'b0, 4'h3, 4'h0, 4'h1, 1'b0, 4'h0, 14'h0009, 1'b1});
    vectors.push_back(vector_t'{8'h00, 8'h62, 1'b1, 1'b1, 14'h3C00, 5'h00, 1'b1,
        2'd0, 2'd0, 2'd0, 8'h00, 1'b1, 4'h0, 4'h0, 4'h0, 1'b1, 4'h0, 14'h0000, 1'b1});
    // Non-Plus code turns the ASIC off
    vectors.push_back(vector_t'{8'h40, 8'h22, 1'b1, 1'b1, 14'h0ABC, 5'h05, 1'b1,
        2'd0, 2'd3, 2'd2, 8'hFF, 1'b0, 4'h0, 4'h3, 4'h2, 1'b0, 4'hA, 14'h0ABC, 1'b0});
    vectors.push_back(vector_t'{8'h80, 8'h82, 1'b1, 1'b1, 14'h2FFF, 5'h06, 1'b1,
        2'd0, 2'd0, 2'd0, 8'h00, 1'b1, 4'h0, 4'h0, 4'h0, 1'b0, 4'hF, 14'h001B, 1'b1});
endtask

// File: verification/video_tb.sv
`timescale 1ns/1ps

module video_tb;

    localparam int half_period  = 20;
    localparam int strobe_limit = 8;

    typedef struct packed {
        gx_video_pkg::byte_t      cfg;
        gx_video_pkg::byte_t      asic;
        logic                     wr_plus;
        logic                     plus;
        gx_video_pkg::ma_t        ma;
        gx_video_pkg::ra_t        ra;
        logic                     de;
        gx_video_pkg::chan2_t     r;
        gx_video_pkg::chan2_t     g;
        gx_video_pkg::chan2_t     b;
        gx_video_pkg::byte_t      q;
        logic                     rnd;
        gx_video_pkg::chan4_t     exp_r;
        gx_video_pkg::chan4_t     exp_g;
        gx_video_pkg::chan4_t     exp_b;
        logic                     exp_spr;
        gx_video_pkg::sprite_id_t exp_id;
        gx_video_pkg::asic_addr_t exp_addr;
        logic                     exp_rd;
    } vector_t;

    logic                     clk_sys;
    logic                     reset;
    logic                     plus_mode;
    logic                     cclk_en;
    gx_video_pkg::ma_t        crtc_ma;
    gx_video_pkg::ra_t        crtc_ra;
    logic                     crtc_de;
    logic [15:0]              cpu_addr;
    gx_video_pkg::byte_t      cpu_data;
    logic                     cpu_wr;
    gx_video_pkg::chan2_t     r_in;
    gx_video_pkg::chan2_t     g_in;
    gx_video_pkg::chan2_t     b_in;
    gx_video_pkg::byte_t      asic_ram_q;
    gx_video_pkg::chan4_t     r_out;
    gx_video_pkg::chan4_t     g_out;
    gx_video_pkg::chan4_t     b_out;
    logic                     sprite_active_out;
    gx_video_pkg::sprite_id_t sprite_id_out;
    gx_video_pkg::asic_addr_t asic_ram_addr;
    logic                     asic_ram_rd;
    logic                     asic_ram_wr;
    gx_video_pkg::byte_t      asic_ram_din;

    // Reference copy of the mode registers
    gx_video_pkg::byte_t model_config;
    gx_video_pkg::byte_t model_mode;
    logic                model_en;
    logic [15:0]         lfsr;
    vector_t             vectors[$];

    `include "video_tb_vectors.svh"

    gx_video_top gx_video_top_i (
        .clk_sys           (clk_sys),
        .reset             (reset),
        .plus_mode         (plus_mode),
        .cclk_en           (cclk_en),
        .crtc_ma           (crtc_ma),
        .crtc_ra           (crtc_ra),
        .crtc_de           (crtc_de),
        .cpu_addr          (cpu_addr),
        .cpu_data          (cpu_data),
        .cpu_wr            (cpu_wr),
        .r_in              (r_in),
        .g_in              (g_in),
        .b_in              (b_in),
        .r_out             (r_out),
        .g_out             (g_out),
        .b_out             (b_out),
        .sprite_active_out (sprite_active_out),
        .sprite_id_out     (sprite_id_out),
        .asic_ram_addr     (asic_ram_addr),
        .asic_ram_rd       (asic_ram_rd),
        .asic_ram_q        (asic_ram_q),
        .asic_ram_wr       (asic_ram_wr),
        .asic_ram_din      (asic_ram_din)
    );

    always #half_period clk_sys = ~clk_sys;

    // Pixel strobe on every other clock
    always @(negedge clk_sys) begin
        cclk_en <= ~cclk_en;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic gx_video_pkg::byte_t random_bits(input int count);
        gx_video_pkg::byte_t value;
        value = 8'h00;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], next_bit()};
        end
        return value;
    endfunction

    // Expected channel for rows with random colours
    function automatic gx_video_pkg::chan4_t model_channel(input logic de, input logic hit,
            input gx_video_pkg::chan2_t mb, input gx_video_pkg::chan2_t stored);
        logic [2:0] total;
        total = {1'b0, mb} + {1'b0, stored};
        if (!de)
            return 4'h0;
        if (model_config == 8'h00 || !(model_en && plus_mode))
            return {2'b00, mb};
        if (model_mode == gx_video_pkg::asic_mode_sprite && !hit)
            return {2'b00, mb};
        if (model_mode == gx_video_pkg::asic_mode_blend)
            return {2'b00, total[2:1]};
        return {2'b00, stored};
    endfunction

    task automatic colour_check(input string name, input gx_video_pkg::chan4_t got,
            input gx_video_pkg::chan4_t want);
        if (got !== want) begin
            stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want));
        end
    endtask

    task automatic sprite_check(input logic got_act, input logic want_act,
            input gx_video_pkg::sprite_id_t got_id, input gx_video_pkg::sprite_id_t want_id);
        if (got_act !== want_act || got_id !== want_id) begin
            stop_run($sformatf("MISMATCH at %0t: sprite %b/%h, expected %b/%h",
                               $time, got_act, got_id, want_act, want_id));
        end
    endtask

    task automatic read_port_check(input gx_video_pkg::asic_addr_t got_addr,
            input gx_video_pkg::asic_addr_t want_addr, input logic got_rd, input logic want_rd);
        if (got_addr !== want_addr || got_rd !== want_rd) begin
            stop_run($sformatf("MISMATCH at %0t: RAM read %h/%b, expected %h/%b",
                               $time, got_addr, got_rd, want_addr, want_rd));
        end
    endtask

    task automatic write_port_check(input logic got_wr, input logic want_wr,
            input gx_video_pkg::byte_t got_din, input gx_video_pkg::byte_t want_din);
        if (got_wr !== want_wr || got_din !== want_din) begin
            stop_run($sformatf("MISMATCH at %0t: RAM write %b/%h, expected %b/%h",
                               $time, got_wr, got_din, want_wr, want_din));
        end
    endtask

    // Counts strobes seen on rising edges, then steps into the stable window
    task automatic wait_strobes(input int count);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count) begin
            @(posedge clk_sys);
            cycles++;
            if (cclk_en) begin
                seen++;
            end
            if (cycles > strobe_limit * count) begin
                stop_run("Timeout: cclk_en strobes stopped arriving");
            end
        end
        #(half_period / 2);
    endtask

    task automatic cpu_write(input logic [15:0] addr, input gx_video_pkg::byte_t data);
        logic port;
        @(negedge clk_sys);
        cpu_addr = addr;
        cpu_data = data;
        cpu_wr   = 1'b1;
        port     = (addr[15:8] == gx_video_pkg::ga_port_hi);
        #(half_period / 2);
        write_port_check(asic_ram_wr, model_en && port, asic_ram_din, data);
        // Register takes the write on the coming rising edge
        if (port && !addr[0]) begin
            if (data[4:0] == 5'd0) begin
                model_config = data;
            end else if (data[4:0] == 5'd2) begin
                model_mode = data;
                model_en   = plus_mode && (data == gx_video_pkg::asic_mode_palette ||
                                           data == gx_video_pkg::asic_mode_sprite  ||
                                           data == gx_video_pkg::asic_mode_blend);
            end
        end
    endtask

    task automatic run_vector(input int index);
        vector_t             v;
        gx_video_pkg::byte_t bits;
        logic                hit;
        v = vectors[index];
        @(negedge clk_sys);
        plus_mode = v.wr_plus;
        cpu_write(16'hBC00, v.cfg);
        cpu_write(16'hBC00, v.asic);
        // Odd address and foreign port must leave the registers alone
        bits = random_bits(8);
        cpu_write(16'hBC01, bits);
        cpu_write(16'h7F00, gx_video_pkg::asic_mode_palette);
        @(negedge clk_sys);
        cpu_wr    = 1'b0;
        plus_mode = v.plus;
        if (v.rnd) begin
            bits = random_bits(2);
            v.r  = bits[1:0];
            bits = random_bits(2);
            v.g  = bits[1:0];
            bits = random_bits(2);
            v.b  = bits[1:0];
            v.q  = random_bits(8);
        end
        crtc_ma    = v.ma;
        crtc_ra    = v.ra;
        crtc_de    = v.de;
        r_in       = v.r;
        g_in       = v.g;
        b_in       = v.b;
        asic_ram_q = v.q;
        wait_strobes(3);
        hit = (v.ma[13:10] == 4'hF);
        if (v.rnd) begin
            v.exp_r = model_channel(v.de, hit, v.r, v.q[1:0]);
            v.exp_g = model_channel(v.de, hit, v.g, v.q[3:2]);
            v.exp_b = model_channel(v.de, hit, v.b, v.q[5:4]);
        end
        colour_check("r_out", r_out, v.exp_r);
        colour_check("g_out", g_out, v.exp_g);
        colour_check("b_out", b_out, v.exp_b);
        sprite_check(sprite_active_out, v.exp_spr, sprite_id_out, v.exp_id);
        read_port_check(asic_ram_addr, v.exp_addr, asic_ram_rd, v.exp_rd);
        write_port_check(asic_ram_wr, 1'b0, asic_ram_din, cpu_data);
        // Read strobe stays low on the clock between strobes
        @(posedge clk_sys);
        #(half_period / 2);
        read_port_check(asic_ram_addr, v.exp_addr, asic_ram_rd, 1'b0);
    endtask

    initial begin
        clk_sys      = 1'b0;
        reset        = 1'b1;
        plus_mode    = 1'b0;
        cclk_en      = 1'b0;
        crtc_ma      = '0;
        crtc_ra      = '0;
        crtc_de      = 1'b0;
        cpu_addr     = 16'h0000;
        cpu_data     = 8'h00;
        cpu_wr       = 1'b0;
        r_in         = 2'd0;
        g_in         = 2'd0;
        b_in         = 2'd0;
        asic_ram_q   = 8'h00;
        model_config = 8'h00;
        model_mode   = 8'h00;
        model_en     = 1'b0;
        lfsr         = 16'd41015;
        repeat (4) @(posedge clk_sys);
        #(half_period / 2);
        // Everything starts dark and idle
        colour_check("r_out", r_out, 4'h0);
        colour_check("g_out", g_out, 4'h0);
        colour_check("b_out", b_out, 4'h0);
        sprite_check(sprite_active_out, 1'b0, sprite_id_out, 4'h0);
        read_port_check(asic_ram_addr, 14'h0000, asic_ram_rd, 1'b0);
        write_port_check(asic_ram_wr, 1'b0, asic_ram_din, 8'h00);
        @(negedge clk_sys);
        reset = 1'b0;
        load_vectors();
        for (int i = 0; i < vectors.size(); i++) begin
            run_vector(i);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: files.f
+incdir+verification
design/gx_video_pkg.sv
design/mode_regs.sv
design/palette_fetch.sv
design/sprite_detect.sv
design/color_mixer.sv
design/gx_video_top.sv
verification/video_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module video_tb -Mdir obj_dir -f files.f

output="$(./obj_dir/Vvideo_tb 2>&1 || true)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Simulation did not report a pass" >&2
exit 1
